/* design/dma_consts.svh */
// ----------------------------------------------------------
// Word size and limits of the copy engine; data is 32 bits
// ----------------------------------------------------------

`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// Bus widths
`define DMA_ADDR_W 32
`define DMA_DATA_W 32
// Bytes per word and the matching byte-offset bits
`define DMA_STRB_W 4
`define DMA_OFFS_W 2

// Byte length field of a request
`define DMA_LEN_W 16
// Beat counts hold ceiling(length / 4) up to and including the maximum
`define DMA_BEAT_W (`DMA_LEN_W - `DMA_OFFS_W + 1)

// Words of decoupling between the read and the write port
`define DMA_BUF_DEPTH 4
// Source reads granted but not yet returned
`define DMA_MAX_INFLIGHT 2

`endif

/* design/dma_pkg.sv */
// ----------------------------------------------------------
// Types only; sizes follow the macros in the consts header
// ----------------------------------------------------------
`default_nettype none

`include "dma_consts.svh"

package dma_pkg;

    // ----------------------------------------------------------
    // Request and response of the copy engine
    // ----------------------------------------------------------
    // One 1D transfer, addresses word aligned
    typedef struct packed {
        logic [`DMA_ADDR_W-1:0] src_addr;
        logic [`DMA_ADDR_W-1:0] dst_addr;
        logic [`DMA_LEN_W-1:0]  length;
        logic                   last;
    } dma_req_t;

    // Only a zero length is ever rejected
    typedef enum logic {
        DMA_ERR_NONE     = 1'b0,
        DMA_ERR_ZERO_LEN = 1'b1
    } dma_err_e;

    typedef struct packed {
        logic     error;
        dma_err_e err_type;
        // Copied from the request
        logic     last;
    } dma_rsp_t;

    // One flag per unit
    typedef struct packed {
        logic fsm_busy;
        logic rd_busy;
        logic buf_busy;
        logic wr_busy;
    } dma_busy_t;

    // ----------------------------------------------------------
    // OBI memory port
    // ----------------------------------------------------------
    // Address phase, held until gnt
    typedef struct packed {
        logic                   req;
        logic                   we;
        logic [`DMA_STRB_W-1:0] be;
        logic [`DMA_ADDR_W-1:0] addr;
        logic [`DMA_DATA_W-1:0] wdata;
    } obi_req_t;

    // Response phase, one rvalid per granted access, in order
    typedef struct packed {
        logic                   gnt;
        logic                   rvalid;
        logic [`DMA_DATA_W-1:0] rdata;
    } obi_rsp_t;

    // Transfer control states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COPY,
        ST_RESP
    } dma_state_e;

endpackage

`default_nettype wire

/* design/dma_ctrl_fsm.sv */
// ----------------------------------------------------------
// Zero length is tested once, at acceptance; no memory traffic then
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module dma_ctrl_fsm (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  dma_pkg::dma_req_t      dma_req_i,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    output dma_pkg::dma_rsp_t      dma_rsp_o,
    output logic                   rsp_valid_o,
    input  logic                   rsp_ready_i,
    input  logic                   copy_done_i,
    output logic                   start_o,
    output logic [`DMA_BEAT_W-1:0] beats_o,
    output logic [`DMA_ADDR_W-1:0] src_base_o,
    output logic [`DMA_ADDR_W-1:0] dst_base_o,
    output logic                   busy_o
);

    import dma_pkg::*;

    dma_state_e             state_q, state_d;
    logic                   start_q;
    logic                   accept;
    logic                   len_zero;
    // Length plus three, one bit wider to keep the carry
    logic [`DMA_LEN_W:0]    len_up;
    logic [`DMA_BEAT_W-1:0] beats_q;
    logic [`DMA_ADDR_W-1:0] src_base_q, dst_base_q;
    dma_rsp_t               rsp_q;

    // Only idle takes a new request
    assign req_ready_o = (state_q == ST_IDLE);
    assign accept      = req_valid_i && req_ready_o;
    assign len_zero    = (dma_req_i.length == '0);
    // ceiling(length / 4)
    assign len_up      = {1'b0, dma_req_i.length} + (`DMA_LEN_W+1)'(3);

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: if (accept) state_d = len_zero ? ST_RESP : ST_COPY;
            // Response may transfer in the completion cycle already
            ST_COPY: if (copy_done_i) state_d = rsp_ready_i ? ST_IDLE : ST_RESP;
            ST_RESP: if (rsp_ready_i) state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // One-cycle start, alongside the latched bases and total
            start_q <= accept && !len_zero;
        end
    end

    // Request fields and the prepared response, loaded at acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            src_base_q     <= dma_req_i.src_addr;
            dst_base_q     <= dma_req_i.dst_addr;
            beats_q        <= len_up[`DMA_LEN_W:`DMA_OFFS_W];
            rsp_q.error    <= len_zero;
            rsp_q.err_type <= len_zero ? DMA_ERR_ZERO_LEN : DMA_ERR_NONE;
            rsp_q.last     <= dma_req_i.last;
        end
    end

    // Valid in the cycle after the final write acknowledge
    assign rsp_valid_o = (state_q == ST_RESP) || ((state_q == ST_COPY) && copy_done_i);
    assign dma_rsp_o   = rsp_q;

    assign start_o    = start_q;
    assign beats_o    = beats_q;
    assign src_base_o = src_base_q;
    assign dst_base_o = dst_base_q;
    assign busy_o     = (state_q != ST_IDLE);

endmodule

`default_nettype wire

/* design/dma_beat_counter.sv */
// ----------------------------------------------------------
// Counts restart on start; copy_done is a one-cycle pulse
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module dma_beat_counter (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   start_i,
    input  logic [`DMA_BEAT_W-1:0] beats_i,
    input  logic                   rd_grant_i,
    input  logic                   wr_ack_i,
    output logic                   rd_left_o,
    output logic [`DMA_BEAT_W-1:0] rd_idx_o,
    output logic [`DMA_BEAT_W-1:0] wr_idx_o,
    output logic                   copy_done_o
);

    // Beat total of the running transfer
    logic [`DMA_BEAT_W-1:0] total_q;
    // Reads granted, writes acknowledged
    logic [`DMA_BEAT_W-1:0] rd_cnt_q;
    logic [`DMA_BEAT_W-1:0] ack_cnt_q;
    logic                   done_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            total_q   <= '0;
            rd_cnt_q  <= '0;
            ack_cnt_q <= '0;
            done_q    <= 1'b0;
        end else if (start_i) begin
            total_q   <= beats_i;
            rd_cnt_q  <= '0;
            ack_cnt_q <= '0;
            done_q    <= 1'b0;
        end else begin
            if (rd_grant_i) rd_cnt_q <= rd_cnt_q + 1'b1;
            if (wr_ack_i) ack_cnt_q <= ack_cnt_q + 1'b1;
            // Final acknowledge seen, flag it one cycle later
            done_q <= wr_ack_i && (ack_cnt_q + 1'b1 == total_q);
        end
    end

    assign rd_left_o   = (rd_cnt_q != total_q);
    assign rd_idx_o    = rd_cnt_q;
    assign wr_idx_o    = ack_cnt_q;
    assign copy_done_o = done_q;

endmodule

`default_nettype wire

/* design/dma_obi_reader.sv */
// ----------------------------------------------------------
// Reads stay within buffer room, so a push is never refused
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module dma_obi_reader (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [`DMA_ADDR_W-1:0]              src_base_i,
    input  logic                                rd_left_i,
    input  logic [`DMA_BEAT_W-1:0]              rd_idx_i,
    input  logic [$clog2(`DMA_BUF_DEPTH+1)-1:0] buf_count_i,
    output logic                                rd_grant_o,
    output logic                                push_valid_o,
    output logic [`DMA_DATA_W-1:0]              push_data_o,
    output dma_pkg::obi_req_t                   obi_req_o,
    input  dma_pkg::obi_rsp_t                   obi_rsp_i,
    output logic                                busy_o
);

    localparam int unsigned IF_W = $clog2(`DMA_MAX_INFLIGHT + 1);

    // Reads granted but not yet returned
    logic [IF_W-1:0]        inflight_q;
    logic                   rd_req;
    logic [`DMA_ADDR_W-1:0] rd_addr;

    // Every term only grows more true until the grant, so req holds
    assign rd_req = rd_left_i && (inflight_q < `DMA_MAX_INFLIGHT) &&
                    ((buf_count_i + inflight_q) < `DMA_BUF_DEPTH);

    // Word address of the next beat
    assign rd_addr = src_base_i + `DMA_ADDR_W'({rd_idx_i, {`DMA_OFFS_W{1'b0}}});

    assign obi_req_o = '{
        req:   rd_req,
        we:    1'b0,
        be:    '1,
        addr:  rd_addr,
        wdata: '0
    };

    assign rd_grant_o = rd_req && obi_rsp_i.gnt;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            inflight_q <= '0;
        end else if (rd_grant_o && !obi_rsp_i.rvalid) begin
            inflight_q <= inflight_q + 1'b1;
        end else if (!rd_grant_o && obi_rsp_i.rvalid) begin
            inflight_q <= inflight_q - 1'b1;
        end
    end

    // Returned words go straight into the buffer
    assign push_valid_o = obi_rsp_i.rvalid;
    assign push_data_o  = obi_rsp_i.rdata;

    assign busy_o = rd_left_i || (inflight_q != '0);

endmodule

`default_nettype wire

/* design/dma_data_buffer.sv */
// ----------------------------------------------------------
// Push side is never refused; the reader bounds the occupancy
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module dma_data_buffer (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                push_valid_i,
    input  logic [`DMA_DATA_W-1:0]              push_data_i,
    output logic                                pop_valid_o,
    output logic [`DMA_DATA_W-1:0]              pop_data_o,
    input  logic                                pop_ready_i,
    output logic [$clog2(`DMA_BUF_DEPTH+1)-1:0] count_o,
    output logic                                busy_o
);

    localparam int unsigned PTR_W = $clog2(`DMA_BUF_DEPTH);
    localparam int unsigned CNT_W = $clog2(`DMA_BUF_DEPTH + 1);

    logic [`DMA_DATA_W-1:0] mem_q [`DMA_BUF_DEPTH];
    logic [PTR_W-1:0]       wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0]       count_q;
    logic                   pop;

    assign pop = pop_valid_o && pop_ready_i;

    // Word storage
    always_ff @(posedge clk_i) begin
        if (push_valid_i) mem_q[wr_ptr_q] <= push_data_i;
    end

    // Pointers wrap at the depth
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(`DMA_BUF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(`DMA_BUF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_valid_i && !pop) count_q <= count_q + 1'b1;
            else if (!push_valid_i && pop) count_q <= count_q - 1'b1;
        end
    end

    // Head word, shown one cycle after its push
    assign pop_valid_o = (count_q != '0);
    assign pop_data_o  = mem_q[rd_ptr_q];
    assign count_o     = count_q;
    assign busy_o      = (count_q != '0);

endmodule

`default_nettype wire

/* design/dma_obi_writer.sv */
// ----------------------------------------------------------
// Full-word writes only; at most one write every two cycles
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module dma_obi_writer (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   start_i,
    input  logic [`DMA_ADDR_W-1:0] dst_base_i,
    input  logic                   pop_valid_i,
    input  logic [`DMA_DATA_W-1:0] pop_data_i,
    output logic                   pop_ready_o,
    output logic                   wr_ack_o,
    output dma_pkg::obi_req_t      obi_req_o,
    input  dma_pkg::obi_rsp_t      obi_rsp_i,
    output logic                   busy_o
);

    logic                   req_q;
    logic                   grant;
    // Granted-write index, addresses the destination
    logic [`DMA_BEAT_W-1:0] idx_q;
    // Writes granted but not yet acknowledged
    logic [`DMA_BEAT_W-1:0] pend_q;

    assign grant = req_q && obi_rsp_i.gnt;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req_q  <= 1'b0;
            idx_q  <= '0;
            pend_q <= '0;
        end else begin
            // Raise req after a head word shows up, drop it on the grant
            req_q <= req_q ? !obi_rsp_i.gnt : pop_valid_i;
            if (start_i) idx_q <= '0;
            else if (grant) idx_q <= idx_q + 1'b1;
            if (grant && !obi_rsp_i.rvalid) pend_q <= pend_q + 1'b1;
            else if (!grant && obi_rsp_i.rvalid) pend_q <= pend_q - 1'b1;
        end
    end

    // Head word stays put until popped, so wdata is stable under req
    assign obi_req_o = '{
        req:   req_q,
        we:    1'b1,
        be:    '1,
        addr:  dst_base_i + `DMA_ADDR_W'({idx_q, {`DMA_OFFS_W{1'b0}}}),
        wdata: pop_data_i
    };

    // Pop on the grant
    assign pop_ready_o = grant;
    // rvalid on the write port is the acknowledge
    assign wr_ack_o    = obi_rsp_i.rvalid;
    assign busy_o      = req_q || (pend_q != '0);

endmodule

`default_nettype wire

/* design/dma_backend.sv */
// ----------------------------------------------------------
// 1D copy engine; word-aligned addresses, one transfer at a time
// Length low bits round up to a whole word
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module dma_backend (
    input  logic              clk_i,
    input  logic              rst_i,
    // Request handshake
    input  dma_pkg::dma_req_t dma_req_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    // Response handshake
    output dma_pkg::dma_rsp_t dma_rsp_o,
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,
    // Source read port
    output dma_pkg::obi_req_t obi_rd_req_o,
    input  dma_pkg::obi_rsp_t obi_rd_rsp_i,
    // Destination write port
    output dma_pkg::obi_req_t obi_wr_req_o,
    input  dma_pkg::obi_rsp_t obi_wr_rsp_i,
    output dma_pkg::dma_busy_t busy_o
);

    // ----------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------
    // Control to counter and data modules
    logic                   start;
    logic [`DMA_BEAT_W-1:0] beats;
    logic [`DMA_ADDR_W-1:0] src_base;
    logic [`DMA_ADDR_W-1:0] dst_base;

    // Beat bookkeeping
    logic                   rd_grant;
    logic                   wr_ack;
    logic                   rd_left;
    logic [`DMA_BEAT_W-1:0] rd_idx;
    logic                   copy_done;

    // Buffer push and pop sides
    logic                                 push_valid;
    logic [`DMA_DATA_W-1:0]               push_data;
    logic                                 pop_valid;
    logic [`DMA_DATA_W-1:0]               pop_data;
    logic                                 pop_ready;
    logic [$clog2(`DMA_BUF_DEPTH+1)-1:0] buf_count;

    // Transfer control
    dma_ctrl_fsm ctrl_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .dma_req_i   (dma_req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .dma_rsp_o   (dma_rsp_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .copy_done_i (copy_done),
        .start_o     (start),
        .beats_o     (beats),
        .src_base_o  (src_base),
        .dst_base_o  (dst_base),
        .busy_o      (busy_o.fsm_busy)
    );

    // Beat counts; the ack count only feeds completion here
    dma_beat_counter counter_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (start),
        .beats_i     (beats),
        .rd_grant_i  (rd_grant),
        .wr_ack_i    (wr_ack),
        .rd_left_o   (rd_left),
        .rd_idx_o    (rd_idx),
        .wr_idx_o    (),
        .copy_done_o (copy_done)
    );

    // Source side
    dma_obi_reader reader_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .src_base_i   (src_base),
        .rd_left_i    (rd_left),
        .rd_idx_i     (rd_idx),
        .buf_count_i  (buf_count),
        .rd_grant_o   (rd_grant),
        .push_valid_o (push_valid),
        .push_data_o  (push_data),
        .obi_req_o    (obi_rd_req_o),
        .obi_rsp_i    (obi_rd_rsp_i),
        .busy_o       (busy_o.rd_busy)
    );

    // Decoupling buffer
    dma_data_buffer buffer_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .push_valid_i (push_valid),
        .push_data_i  (push_data),
        .pop_valid_o  (pop_valid),
        .pop_data_o   (pop_data),
        .pop_ready_i  (pop_ready),
        .count_o      (buf_count),
        .busy_o       (busy_o.buf_busy)
    );

    // Destination side
    dma_obi_writer writer_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (start),
        .dst_base_i  (dst_base),
        .pop_valid_i (pop_valid),
        .pop_data_i  (pop_data),
        .pop_ready_o (pop_ready),
        .wr_ack_o    (wr_ack),
        .obi_req_o   (obi_wr_req_o),
        .obi_rsp_i   (obi_wr_rsp_i),
        .busy_o      (busy_o.wr_busy)
    );

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
// ----------------------------------------------------------
// 40 ns clock; reset high for the first 10 rising edges
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    // Free-running clock, first rising edge at 20 ns
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // Release 1 ns after the tenth rising edge, like any other input
    initial begin
        rst_o = 1'b1;
        repeat (10) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/tb_mem_model.sv */
// ----------------------------------------------------------
// OBI memory, random gnt stalls, rvalid 1 to 3 cycles after grant
// Unwritten words read back a pattern of their full address
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module tb_mem_model (
    input  logic              clk_i,
    input  logic              rst_i,
    input  dma_pkg::obi_req_t obi_req_i,
    output dma_pkg::obi_rsp_t obi_rsp_o
);

    import dma_pkg::*;

    // Words by byte address
    logic [`DMA_DATA_W-1:0] mem_q [logic [`DMA_ADDR_W-1:0]];
    // Responses waiting for their cycle, oldest first
    logic [`DMA_DATA_W-1:0] rsp_data_q [$];
    int                     rsp_due_q [$];
    int                     cycle;
    int                     last_due;
    int                     due;
    logic                   granted;
    logic                   in_reset;
    logic [`DMA_DATA_W-1:0] rdata;

    // Odd multiplier, so every address gives its own word
    function automatic logic [`DMA_DATA_W-1:0] fill_word(input logic [`DMA_ADDR_W-1:0] addr);
        return addr * 32'h9E37_79B1;
    endfunction

    function automatic logic [`DMA_DATA_W-1:0] read_word(input logic [`DMA_ADDR_W-1:0] addr);
        if (mem_q.exists(addr)) begin
            return mem_q[addr];
        end
        return fill_word(addr);
    endfunction

    task automatic write_word(input logic [`DMA_ADDR_W-1:0] addr,
                              input logic [`DMA_DATA_W-1:0] data);
        mem_q[addr] = data;
    endtask

    task automatic clear_all();
        mem_q.delete();
    endtask

    function automatic int word_count();
        return mem_q.num();
    endfunction

    initial begin
        obi_rsp_o = '0;
        cycle     = 0;
        last_due  = -1;
    end

    // Sample the address phase on the edge, answer 1 ns later
    always @(posedge clk_i) begin
        in_reset = rst_i;
        granted  = obi_req_i.req && obi_rsp_o.gnt && !in_reset;
        if (granted) begin
            rdata = '0;
            if (obi_req_i.we) begin
                write_word(obi_req_i.addr, obi_req_i.wdata);
            end else begin
                rdata = read_word(obi_req_i.addr);
            end
            // Random latency, never overtaking an older access
            due = cycle + int'($urandom % 3);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            rsp_due_q.push_back(due);
            rsp_data_q.push_back(rdata);
        end
        #1;
        // Roughly one cycle in four stalls the grant
        obi_rsp_o.gnt    = !in_reset && (($urandom % 4) != 0);
        obi_rsp_o.rvalid = 1'b0;
        obi_rsp_o.rdata  = '0;
        // At most one response per cycle, in grant order
        if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cycle) begin
            obi_rsp_o.rvalid = 1'b1;
            obi_rsp_o.rdata  = rsp_data_q.pop_front();
            rsp_due_q.delete(0);
        end
        cycle++;
    end

endmodule

`default_nettype wire

/* testbench/tb_dma_backend.sv */
// ----------------------------------------------------------
// Copy engine testbench; both memories stall at random
// Stops at the first failed check
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module tb_dma_backend;

    import dma_pkg::*;

    // Request lengths in bytes, one transfer each
    localparam int N_TESTS = 6;
    localparam int unsigned LENS [N_TESTS] = '{4, 0, 6, 40, 1, 28};

    logic      clk;
    logic      rst;
    dma_req_t  dma_req;
    logic      req_valid;
    logic      req_ready;
    dma_rsp_t  dma_rsp;
    logic      rsp_valid;
    logic      rsp_ready;
    obi_req_t  rd_req;
    obi_rsp_t  rd_rsp;
    obi_req_t  wr_req;
    obi_rsp_t  wr_rsp;
    dma_busy_t busy;

    // ----------------------------------------------------------
    // Monitor state
    // ----------------------------------------------------------
    logic                   outstanding;
    logic                   copy_active;
    logic                   zero_accepted;
    logic                   rsp_held;
    dma_rsp_t               rsp_prev;
    dma_rsp_t               rsp_seen;
    int                     rsp_count;
    int                     inflight;
    int                     next_inflight;
    // Words read back but not yet written out
    int                     words_held;
    // Running transfer, for the write range check
    logic [`DMA_ADDR_W-1:0] cur_dst;
    int                     cur_beats;
    // Source words of the running transfer, by beat
    logic [`DMA_DATA_W-1:0] src_words [$];
    int                     stretch;

    tb_clk_gen clk_gen_inst (
        .clk_o (clk),
        .rst_o (rst)
    );

    dma_backend dma_backend_inst (
        .clk_i        (clk),
        .rst_i        (rst),
        .dma_req_i    (dma_req),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .dma_rsp_o    (dma_rsp),
        .rsp_valid_o  (rsp_valid),
        .rsp_ready_i  (rsp_ready),
        .obi_rd_req_o (rd_req),
        .obi_rd_rsp_i (rd_rsp),
        .obi_wr_req_o (wr_req),
        .obi_wr_rsp_i (wr_rsp),
        .busy_o       (busy)
    );

    tb_mem_model src_mem (
        .clk_i     (clk),
        .rst_i     (rst),
        .obi_req_i (rd_req),
        .obi_rsp_o (rd_rsp)
    );

    tb_mem_model dst_mem (
        .clk_i     (clk),
        .rst_i     (rst),
        .obi_req_i (wr_req),
        .obi_rsp_o (wr_rsp)
    );

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected === actual)
            else stop_run($sformatf("mismatch at %0t: %s expected 0x%0h, got 0x%0h",
                                    $time, name, expected, actual));
    endtask

    // Whole words, length rounded up
    function automatic int beats_of(input int unsigned len);
        return (len + 3) / 4;
    endfunction

    // Reset, a fixed budget per request and room for each beat
    function automatic int watchdog_cycles();
        int cycles;
        int t;
        cycles = 10 + 100 * N_TESTS;
        for (t = 0; t < N_TESTS; t++) begin
            cycles += 60 * beats_of(LENS[t]);
        end
        return cycles;
    endfunction

    // One request through to its response, then a look at the memory
    task automatic run_copy(input int t);
        int                     beats;
        int                     i;
        logic [`DMA_ADDR_W-1:0] src;
        logic [`DMA_ADDR_W-1:0] dst;
        logic [`DMA_DATA_W-1:0] word;
        logic                   last;
        beats = beats_of(LENS[t]);
        src   = 32'h0000_1000 + 32'(t) * 32'h100;
        dst   = 32'h0004_0000 + 32'(t) * 32'h100;
        last  = t[0];
        src_words.delete();
        dst_mem.clear_all();
        for (i = 0; i < beats; i++) begin
            word = $urandom;
            src_words.push_back(word);
            src_mem.write_word(src + 32'(4 * i), word);
        end
        cur_dst   = dst;
        cur_beats = beats;
        @(posedge clk);
        #1;
        dma_req   = '{src_addr: src, dst_addr: dst, length: `DMA_LEN_W'(LENS[t]), last: last};
        req_valid = 1'b1;
        // Held until ready is seen on a rising edge
        do @(posedge clk); while (!req_ready);
        #1;
        req_valid = 1'b0;
        dma_req   = '0;
        wait (rsp_count == t + 1);
        #1;
        check_value("dma_rsp_o.error", beats == 0, rsp_seen.error);
        check_value("dma_rsp_o.err_type", (beats == 0) ? DMA_ERR_ZERO_LEN : DMA_ERR_NONE,
                    rsp_seen.err_type);
        check_value("dma_rsp_o.last", last, rsp_seen.last);
        check_value("destination word count", beats, dst_mem.word_count());
        for (i = 0; i < beats; i++) begin
            check_value($sformatf("destination word %0d", i), src_words[i],
                        dst_mem.read_word(dst + 32'(4 * i)));
        end
    endtask

    // ----------------------------------------------------------
    // Bus monitor, sampled on the rising edge
    // ----------------------------------------------------------
    always @(posedge clk) begin
        if (!rst) begin
            assert (copy_active || !(rd_req.req || wr_req.req))
                else stop_run("memory request raised while no copy was running");
            assert (!outstanding || !req_ready)
                else stop_run("req_ready_o went high before the response transferred");
            assert (!rsp_valid || outstanding)
                else stop_run("response given with no request pending");
            // Idle with the response gone means nothing may be busy
            if (req_ready) begin
                check_value("busy_o", '0, busy);
            end
            // Each unit flags its own activity
            check_value("busy_o.fsm_busy", outstanding, busy.fsm_busy);
            check_value("busy_o.buf_busy", words_held != 0, busy.buf_busy);
            if (rd_req.req || inflight != 0) begin
                check_value("busy_o.rd_busy", 1'b1, busy.rd_busy);
            end
            if (wr_req.req) begin
                check_value("busy_o.wr_busy", 1'b1, busy.wr_busy);
            end
            // Zero length answers in the cycle after acceptance
            if (zero_accepted) begin
                check_value("rsp_valid_o", 1'b1, rsp_valid);
                check_value("dma_rsp_o.err_type", DMA_ERR_ZERO_LEN, dma_rsp.err_type);
            end
            if (rsp_held) begin
                check_value("rsp_valid_o", 1'b1, rsp_valid);
                check_value("dma_rsp_o", rsp_prev, dma_rsp);
            end
            next_inflight = inflight + int'(rd_req.req && rd_rsp.gnt) - int'(rd_rsp.rvalid);
            assert (next_inflight <= `DMA_MAX_INFLIGHT)
                else stop_run("too many source reads granted but not returned");
            inflight <= next_inflight;
            words_held <= words_held + int'(rd_rsp.rvalid) - int'(wr_req.req && wr_rsp.gnt);
            if (wr_req.req && wr_rsp.gnt) begin
                assert (wr_req.addr >= cur_dst && wr_req.addr < cur_dst + 32'(4 * cur_beats)
                        && wr_req.addr[`DMA_OFFS_W-1:0] == '0)
                    else stop_run($sformatf("write to 0x%0h outside the destination range",
                                            wr_req.addr));
                check_value("obi_wr_req_o.be", 4'hF, wr_req.be);
            end
            // Handshake tracking
            zero_accepted <= req_valid && req_ready && (dma_req.length == '0);
            if (req_valid && req_ready) begin
                outstanding <= 1'b1;
                copy_active <= (dma_req.length != '0);
            end
            if (rsp_valid && rsp_ready) begin
                outstanding <= 1'b0;
                copy_active <= 1'b0;
                rsp_seen    <= dma_rsp;
                rsp_count   <= rsp_count + 1;
            end
            rsp_held <= rsp_valid && !rsp_ready;
            rsp_prev <= dma_rsp;
        end
    end

    // Response back-pressure in random stretches
    initial begin
        rsp_ready = 1'b0;
        stretch   = 0;
        forever begin
            @(posedge clk);
            #1;
            if (stretch == 0) begin
                rsp_ready = 1'($urandom_range(1, 0));
                stretch   = $urandom_range(6, 1);
            end
            stretch--;
        end
    end

    initial begin
        repeat (watchdog_cycles()) @(posedge clk);
        stop_run("watchdog expired, the copy engine stopped making progress");
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        void'($urandom(10));
        $timeformat(-9, 0, " ns", 0);
        dma_req       = '0;
        req_valid     = 1'b0;
        outstanding   = 1'b0;
        copy_active   = 1'b0;
        zero_accepted = 1'b0;
        rsp_held      = 1'b0;
        rsp_prev      = '0;
        rsp_seen      = '0;
        rsp_count     = 0;
        inflight      = 0;
        words_held    = 0;
        cur_dst       = '0;
        cur_beats     = 0;
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        @(posedge clk);
        // Quiet after reset
        check_value("req_ready_o", 1'b1, req_ready);
        check_value("rsp_valid_o", 1'b0, rsp_valid);
        check_value("obi_rd_req_o.req", 1'b0, rd_req.req);
        check_value("obi_wr_req_o.req", 1'b0, wr_req.req);
        check_value("busy_o", '0, busy);
        for (int t = 0; t < N_TESTS; t++) begin
            run_copy(t);
        end
        // No late extra response
        repeat (20) @(posedge clk);
        check_value("response count", N_TESTS, rsp_count);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/dma_pkg.sv
design/dma_ctrl_fsm.sv
design/dma_beat_counter.sv
design/dma_obi_reader.sv
design/dma_data_buffer.sv
design/dma_obi_writer.sv
design/dma_backend.sv
testbench/tb_clk_gen.sv
testbench/tb_mem_model.sv
testbench/tb_dma_backend.sv

/* Bender.yml */
package:
  name: dma_backend

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/dma_pkg.sv
      - design/dma_ctrl_fsm.sv
      - design/dma_beat_counter.sv
      - design/dma_obi_reader.sv
      - design/dma_data_buffer.sv
      - design/dma_obi_writer.sv
      - design/dma_backend.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_mem_model.sv
      - testbench/tb_dma_backend.sv
